/* usb_tx_pkg.sv */
`default_nettype none

package usb_tx_pkg;

	// Request codes on tx_packet
	localparam logic [2:0] REQ_NONE  = 3'd0;
	localparam logic [2:0] REQ_DATA0 = 3'd1;
	localparam logic [2:0] REQ_ACK   = 3'd2;
	localparam logic [2:0] REQ_NAK   = 3'd3;
	localparam logic [2:0] REQ_STALL = 3'd4;

	localparam logic [7:0] PID_DATA0 = 8'hC3;
	localparam logic [7:0] PID_ACK   = 8'hD2;
	localparam logic [7:0] PID_NAK   = 8'h5A;
	localparam logic [7:0] PID_STALL = 8'h1E;

	localparam logic [7:0] SYNC_BYTE = 8'h80; // KJKJKJKK on the line

	localparam logic [15:0] CRC16_POLY = 16'h8005;
	localparam logic [15:0] CRC16_INIT = 16'hFFFF;

	localparam int FIFO_DEPTH  = 64;
	localparam int FIFO_CNT_W  = 7;
	localparam int FIFO_PTR_W  = 6;
	localparam int STUFF_LIMIT = 6; // Ones before a stuffed zero

	// Controller states
	localparam logic [2:0] ST_IDLE   = 3'd0;
	localparam logic [2:0] ST_ERR    = 3'd1;
	localparam logic [2:0] ST_SYNC   = 3'd2;
	localparam logic [2:0] ST_PID    = 3'd3;
	localparam logic [2:0] ST_DATA   = 3'd4;
	localparam logic [2:0] ST_CRC_LO = 3'd5;
	localparam logic [2:0] ST_CRC_HI = 3'd6;
	localparam logic [2:0] ST_EOP    = 3'd7;

	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [3:0] pid_check; // Complement of pid_code
			logic [3:0] pid_code;
		} fields;
	} pid_byte_u;

endpackage

`default_nettype wire

/* usb_tx_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_tx_fifo (
	input wire clk,
	input wire n_rst,
	input wire [7:0] wr_data,
	input wire wr_en,
	input wire get_tx,
	output logic [7:0] fifo_data,
	output logic [usb_tx_pkg::FIFO_CNT_W-1:0] buffer_occupancy
);

	logic [7:0] mem [usb_tx_pkg::FIFO_DEPTH];
	logic [usb_tx_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [usb_tx_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [usb_tx_pkg::FIFO_CNT_W-1:0] count;
	logic push;
	logic pop;

	assign push = wr_en && (count != usb_tx_pkg::FIFO_DEPTH); // Dropped when full
	assign pop = get_tx && (count != '0);
	assign fifo_data = mem[rd_ptr]; // Head entry
	assign buffer_occupancy = count;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* usb_tx_crc16.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_tx_crc16 (
	input wire clk,
	input wire n_rst,
	input wire crc_clear,
	input wire crc_update,
	input wire [7:0] crc_byte,
	output logic [15:0] crc_out
);

	logic [15:0] crc_reg;
	logic [15:0] crc_next;
	logic [15:0] poly_rev;

	// Register kept bit reversed so the low byte goes out first on the wire
	assign poly_rev = {<<{usb_tx_pkg::CRC16_POLY}};
	assign crc_out = ~crc_reg;

	always_comb begin
		crc_next = crc_reg;
		for (int i = 0; i < 8; i++) begin
			if (crc_next[0] ^ crc_byte[i]) begin
				crc_next = (crc_next >> 1) ^ poly_rev;
			end else begin
				crc_next = crc_next >> 1;
			end
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			crc_reg <= usb_tx_pkg::CRC16_INIT;
		end else if (crc_clear) begin
			crc_reg <= usb_tx_pkg::CRC16_INIT;
		end else if (crc_update) begin
			crc_reg <= crc_next;
		end
	end

endmodule

`default_nettype wire

/* usb_tx_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_tx_serializer (
	input wire clk,
	input wire n_rst,
	input wire load,
	input wire [7:0] byte_out,
	output logic bit_out,
	output logic bit_valid,
	output logic byte_done
);

	logic [7:0] shreg;
	logic [3:0] bits_left; // Data bits left, current one included
	logic [2:0] ones_cnt;
	logic [2:0] ones_next;
	logic busy;
	logic stuff; // Current cycle is a stuffed zero
	logic stuff_due;

	assign ones_next = shreg[0] ? ones_cnt + 3'd1 : 3'd0;
	assign stuff_due = busy && !stuff && (ones_next == 3'(usb_tx_pkg::STUFF_LIMIT));

	assign bit_valid = busy;
	assign bit_out = stuff ? 1'b0 : shreg[0];
	assign byte_done = busy && !stuff_due &&
		(stuff ? (bits_left == 4'd0) : (bits_left == 4'd1));

	always_ff @(posedge clk) begin
		if (load) begin
			shreg <= byte_out;
		end else if (busy && !stuff) begin
			shreg <= shreg >> 1; // LSB first
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			busy <= 1'b0;
			stuff <= 1'b0;
			bits_left <= 4'd0;
			ones_cnt <= 3'd0;
		end else begin
			if (!busy || stuff) begin
				ones_cnt <= 3'd0; // Idle means the next byte is SYNC
			end else begin
				ones_cnt <= ones_next; // Run carries across bytes
			end
			stuff <= stuff_due;
			if (load) begin
				bits_left <= 4'd8;
				busy <= 1'b1;
			end else if (byte_done) begin
				busy <= 1'b0;
			end else if (busy && !stuff) begin
				bits_left <= bits_left - 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* usb_tx_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_tx_encoder (
	input wire clk,
	input wire n_rst,
	input wire bit_valid,
	input wire bit_out,
	input wire eop_req,
	output logic dp,
	output logic dm,
	output logic eop_done
);

	logic level; // 1 is J
	logic [1:0] eop_ph;
	logic cur;
	logic se0;

	// NRZI, a zero toggles the line
	assign cur = bit_valid ? (bit_out ? level : ~level) : level;
	assign se0 = (eop_ph == 2'd1) || (eop_ph == 2'd2);
	assign dp = se0 ? 1'b0 : cur;
	assign dm = se0 ? 1'b0 : ~cur;
	assign eop_done = (eop_ph == 2'd3); // J after two SE0 cycles

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			level <= 1'b1;
			eop_ph <= 2'd0;
		end else begin
			if (eop_req) begin
				eop_ph <= 2'd1;
			end else if (eop_ph != 2'd0) begin
				eop_ph <= eop_ph + 2'd1; // Back to idle after the J cycle
			end
			if (se0) begin
				level <= 1'b1; // Line returns to J after SE0
			end else begin
				level <= cur;
			end
		end
	end

endmodule

`default_nettype wire

/* usb_tx_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_tx_ctrl (
	input wire clk,
	input wire n_rst,
	input wire [2:0] tx_packet,
	input wire byte_done,
	input wire eop_done,
	input wire [7:0] fifo_data,
	input wire [usb_tx_pkg::FIFO_CNT_W-1:0] buffer_occupancy,
	input wire [15:0] crc_out,
	output logic load,
	output logic [7:0] byte_out,
	output logic get_tx,
	output logic crc_clear,
	output logic crc_update,
	output logic eop_req,
	output logic tx_transfer_active,
	output logic tx_err
);

	logic [2:0] state;
	logic [2:0] next_state;
	logic [2:0] req_q;
	logic [2:0] req_d;
	logic err_d;
	logic has_data;
	logic [7:0] pid_sel;
	usb_tx_pkg::pid_byte_u pid;

	assign has_data = (buffer_occupancy != '0);
	assign tx_transfer_active = (state != usb_tx_pkg::ST_IDLE) &&
		(state != usb_tx_pkg::ST_ERR);

	always_comb begin
		case (req_q)
			usb_tx_pkg::REQ_DATA0: pid_sel = usb_tx_pkg::PID_DATA0;
			usb_tx_pkg::REQ_ACK: pid_sel = usb_tx_pkg::PID_ACK;
			usb_tx_pkg::REQ_NAK: pid_sel = usb_tx_pkg::PID_NAK;
			default: pid_sel = usb_tx_pkg::PID_STALL;
		endcase
		pid.raw = pid_sel;
	end

	// Next byte is loaded in the same cycle as byte_done, so bytes run back to back
	always_comb begin
		next_state = state;
		req_d = req_q;
		err_d = 1'b0;
		load = 1'b0;
		byte_out = 8'h00;
		get_tx = 1'b0;
		crc_clear = 1'b0;
		crc_update = 1'b0;
		eop_req = 1'b0;
		case (state)
			usb_tx_pkg::ST_IDLE: begin
				case (tx_packet)
					usb_tx_pkg::REQ_NONE: begin
						next_state = usb_tx_pkg::ST_IDLE;
					end
					usb_tx_pkg::REQ_DATA0,
					usb_tx_pkg::REQ_ACK,
					usb_tx_pkg::REQ_NAK,
					usb_tx_pkg::REQ_STALL: begin
						req_d = tx_packet;
						load = 1'b1; // SYNC goes out while idle
						byte_out = usb_tx_pkg::SYNC_BYTE;
						crc_clear = 1'b1;
						next_state = usb_tx_pkg::ST_SYNC;
					end
					default: begin
						err_d = 1'b1;
						next_state = usb_tx_pkg::ST_ERR;
					end
				endcase
			end
			usb_tx_pkg::ST_ERR: begin
				if (tx_packet == usb_tx_pkg::REQ_NONE) begin
					next_state = usb_tx_pkg::ST_IDLE; // Bad code must be withdrawn
				end
			end
			usb_tx_pkg::ST_SYNC: begin
				if (byte_done) begin
					load = 1'b1;
					byte_out = pid.raw;
					next_state = usb_tx_pkg::ST_PID;
				end
			end
			usb_tx_pkg::ST_PID,
			usb_tx_pkg::ST_DATA: begin
				if (byte_done) begin
					if (req_q != usb_tx_pkg::REQ_DATA0) begin
						eop_req = 1'b1; // Handshake has no payload or CRC
						next_state = usb_tx_pkg::ST_EOP;
					end else if (has_data) begin
						load = 1'b1;
						byte_out = fifo_data;
						get_tx = 1'b1;
						crc_update = 1'b1;
						next_state = usb_tx_pkg::ST_DATA;
					end else begin
						load = 1'b1;
						byte_out = crc_out[7:0];
						next_state = usb_tx_pkg::ST_CRC_LO;
					end
				end
			end
			usb_tx_pkg::ST_CRC_LO: begin
				if (byte_done) begin
					load = 1'b1;
					byte_out = crc_out[15:8];
					next_state = usb_tx_pkg::ST_CRC_HI;
				end
			end
			usb_tx_pkg::ST_CRC_HI: begin
				if (byte_done) begin
					eop_req = 1'b1;
					next_state = usb_tx_pkg::ST_EOP;
				end
			end
			usb_tx_pkg::ST_EOP: begin
				if (eop_done) begin
					next_state = usb_tx_pkg::ST_IDLE;
				end
			end
			default: begin
				next_state = usb_tx_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= usb_tx_pkg::ST_IDLE;
			req_q <= usb_tx_pkg::REQ_NONE;
			tx_err <= 1'b0;
		end else begin
			state <= next_state;
			req_q <= req_d;
			tx_err <= err_d; // One pulse on entry to ERR
		end
	end

endmodule

`default_nettype wire

/* usb_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_tx (
	input wire clk,
	input wire n_rst,
	input wire [7:0] wr_data,
	input wire wr_en,
	output logic [usb_tx_pkg::FIFO_CNT_W-1:0] buffer_occupancy,
	input wire [2:0] tx_packet,
	output logic tx_transfer_active,
	output logic tx_err,
	output logic dp,
	output logic dm
);

	logic load;
	logic [7:0] byte_out;
	logic byte_done;
	logic get_tx;
	logic [7:0] fifo_data;
	logic crc_clear;
	logic crc_update;
	logic [15:0] crc_out;
	logic eop_req;
	logic eop_done;
	logic bit_out;
	logic bit_valid;

	usb_tx_ctrl u_ctrl (
		.clk(clk),
		.n_rst(n_rst),
		.tx_packet(tx_packet),
		.byte_done(byte_done),
		.eop_done(eop_done),
		.fifo_data(fifo_data),
		.buffer_occupancy(buffer_occupancy),
		.crc_out(crc_out),
		.load(load),
		.byte_out(byte_out),
		.get_tx(get_tx),
		.crc_clear(crc_clear),
		.crc_update(crc_update),
		.eop_req(eop_req),
		.tx_transfer_active(tx_transfer_active),
		.tx_err(tx_err)
	);

	usb_tx_fifo u_fifo (
		.clk(clk),
		.n_rst(n_rst),
		.wr_data(wr_data),
		.wr_en(wr_en),
		.get_tx(get_tx),
		.fifo_data(fifo_data),
		.buffer_occupancy(buffer_occupancy)
	);

	usb_tx_crc16 u_crc16 (
		.clk(clk),
		.n_rst(n_rst),
		.crc_clear(crc_clear),
		.crc_update(crc_update),
		.crc_byte(byte_out), // Equals fifo_data while crc_update is high
		.crc_out(crc_out)
	);

	usb_tx_serializer u_serializer (
		.clk(clk),
		.n_rst(n_rst),
		.load(load),
		.byte_out(byte_out),
		.bit_out(bit_out),
		.bit_valid(bit_valid),
		.byte_done(byte_done)
	);

	usb_tx_encoder u_encoder (
		.clk(clk),
		.n_rst(n_rst),
		.bit_valid(bit_valid),
		.bit_out(bit_out),
		.eop_req(eop_req),
		.dp(dp),
		.dm(dm),
		.eop_done(eop_done)
	);

endmodule

`default_nettype wire

/* tb_usb_tx_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_usb_tx_assert (
	input wire clk,
	input wire n_rst,
	input wire [2:0] tx_packet,
	input wire tx_transfer_active,
	input wire tx_err,
	input wire dp,
	input wire dm
);

	// SE1 is never a legal line state
	no_se1: assert property (@(posedge clk) disable iff (!n_rst) !(dp && dm))
		else $error("dp and dm are both high");

	err_outside_transfer: assert property (@(posedge clk) disable iff (!n_rst)
		!(tx_err && tx_transfer_active))
		else $error("tx_err is high during a transfer");

	active_needs_request: assert property (@(posedge clk) disable iff (!n_rst)
		$rose(tx_transfer_active) |-> $past(tx_packet) != usb_tx_pkg::REQ_NONE)
		else $error("tx_transfer_active rose without a request");

endmodule

`default_nettype wire

/* tb_usb_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_usb_tx;

	typedef logic [7:0] byte_q_t[$];

	logic clk;
	logic n_rst;
	logic [7:0] wr_data;
	logic wr_en;
	logic [2:0] tx_packet;
	wire [usb_tx_pkg::FIFO_CNT_W-1:0] buffer_occupancy;
	wire tx_transfer_active;
	wire tx_err;
	wire dp;
	wire dm;
	int errors;
	int checks;
	byte_q_t rx_bytes; // Bytes decoded from the line
	int rx_stuffed;

	usb_tx u_usb_tx (
		.clk(clk),
		.n_rst(n_rst),
		.wr_data(wr_data),
		.wr_en(wr_en),
		.buffer_occupancy(buffer_occupancy),
		.tx_packet(tx_packet),
		.tx_transfer_active(tx_transfer_active),
		.tx_err(tx_err),
		.dp(dp),
		.dm(dm)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s at %0t", what, $time);
		errors++;
	endtask

	task automatic report_test(input string name, input int err_start);
		$display("Test %s finished with %0d errors", name, errors - err_start);
	endtask

	// Shift-left form of the USB CRC16, highest coefficient goes out first
	function automatic logic [15:0] crc16_ref(input byte_q_t data);
		logic [15:0] crc;
		logic fb;
		crc = usb_tx_pkg::CRC16_INIT;
		foreach (data[n]) begin
			for (int i = 0; i < 8; i++) begin
				fb = crc[15] ^ data[n][i];
				crc = {crc[14:0], 1'b0} ^ (fb ? usb_tx_pkg::CRC16_POLY : 16'h0000);
			end
		end
		crc = ~crc;
		return {<<{crc}}; // Bit 0 is the first CRC bit on the wire
	endfunction

	function automatic int stuffed_bits(input byte_q_t data);
		int ones;
		int total;
		ones = 0;
		total = 0;
		foreach (data[n]) begin
			for (int i = 0; i < 8; i++) begin
				ones = data[n][i] ? ones + 1 : 0;
				if (ones == usb_tx_pkg::STUFF_LIMIT) begin
					total++;
					ones = 0;
				end
			end
		end
		return total;
	endfunction

	function automatic byte_q_t data0_packet(input byte_q_t payload);
		byte_q_t pkt;
		logic [15:0] crc;
		crc = crc16_ref(payload);
		pkt.push_back(usb_tx_pkg::SYNC_BYTE);
		pkt.push_back(usb_tx_pkg::PID_DATA0);
		foreach (payload[n]) begin
			pkt.push_back(payload[n]);
		end
		pkt.push_back(crc[7:0]); // Low byte first
		pkt.push_back(crc[15:8]);
		return pkt;
	endfunction

	// Line decoder, samples at the falling edge where dp/dm are settled
	task automatic capture_packet();
		int cycles;
		int bit_cnt;
		int ones;
		logic level;
		logic bit_val;
		logic [7:0] shift;
		rx_bytes.delete();
		rx_stuffed = 0;
		cycles = 0;
		while (dp === 1'b1 && dm === 1'b0 && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		if (dp === 1'b1 && dm === 1'b0) begin
			report_timeout("the packet to start");
			return;
		end
		level = 1'b1;
		bit_cnt = 0;
		ones = 0;
		shift = 8'h00;
		cycles = 0;
		while ((dp !== 1'b0 || dm !== 1'b0) && cycles < 1000) begin
			bit_val = (dp === level); // NRZI, no transition is a one
			level = dp;
			if (ones == usb_tx_pkg::STUFF_LIMIT) begin
				check_value("stuffed bit", bit_val, 1'b0);
				rx_stuffed++;
				ones = 0;
			end else begin
				shift = {bit_val, shift[7:1]};
				ones = bit_val ? ones + 1 : 0;
				bit_cnt++;
				if (bit_cnt == 8) begin
					rx_bytes.push_back(shift);
					bit_cnt = 0;
				end
			end
			@(negedge clk);
			cycles++;
		end
		if (dp !== 1'b0 || dm !== 1'b0) begin
			report_timeout("the end of packet");
			return;
		end
		check_value("bits after last byte", bit_cnt, 0);
		@(negedge clk);
		check_value("second SE0 cycle", {dp, dm}, 2'b00);
		@(negedge clk);
		check_value("J after EOP", {dp, dm}, 2'b10);
	endtask

	task automatic run_packet(input logic [2:0] code);
		tx_packet = code;
		@(negedge clk);
		tx_packet = usb_tx_pkg::REQ_NONE;
		check_value("tx_transfer_active at start", tx_transfer_active, 1'b1);
		capture_packet();
		@(negedge clk);
		check_value("tx_transfer_active after EOP", tx_transfer_active, 1'b0);
	endtask

	task automatic check_packet(input byte_q_t exp);
		check_value("byte count", rx_bytes.size(), exp.size());
		foreach (exp[n]) begin
			if (n < rx_bytes.size()) begin
				check_value($sformatf("byte %0d", n), rx_bytes[n], exp[n]);
			end
		end
		check_value("stuffed bit count", rx_stuffed, stuffed_bits(exp));
	endtask

	task automatic write_fifo(input byte_q_t data);
		foreach (data[n]) begin
			wr_data = data[n];
			wr_en = 1'b1;
			@(negedge clk);
		end
		wr_en = 1'b0;
		check_value("buffer_occupancy after writes", buffer_occupancy, data.size());
	endtask

	task automatic run_data0(input byte_q_t payload);
		write_fifo(payload);
		run_packet(usb_tx_pkg::REQ_DATA0);
		check_packet(data0_packet(payload));
		check_value("buffer_occupancy after packet", buffer_occupancy, 0);
	endtask

	task automatic test_handshakes();
		logic [2:0] codes[3];
		logic [7:0] pids[3];
		usb_tx_pkg::pid_byte_u pid;
		logic [3:0] code_inv;
		byte_q_t exp;
		int err_start;
		err_start = errors;
		codes = '{usb_tx_pkg::REQ_ACK, usb_tx_pkg::REQ_NAK, usb_tx_pkg::REQ_STALL};
		pids = '{usb_tx_pkg::PID_ACK, usb_tx_pkg::PID_NAK, usb_tx_pkg::PID_STALL};
		for (int k = 0; k < 3; k++) begin
			run_packet(codes[k]);
			exp.delete();
			exp.push_back(usb_tx_pkg::SYNC_BYTE);
			exp.push_back(pids[k]);
			check_packet(exp);
			if (rx_bytes.size() > 1) begin
				pid.raw = rx_bytes[1];
				code_inv = ~pid.fields.pid_code;
				check_value("PID check nibble", pid.fields.pid_check, code_inv);
			end
		end
		report_test("handshakes", err_start);
	endtask

	task automatic test_random_payload();
		byte_q_t payload;
		int len;
		int err_start;
		err_start = errors;
		len = $urandom_range(20, 1);
		for (int n = 0; n < len; n++) begin
			payload.push_back(8'($urandom));
		end
		run_data0(payload);
		report_test("random_payload", err_start);
	endtask

	task automatic test_all_ones();
		byte_q_t payload;
		int err_start;
		err_start = errors;
		for (int n = 0; n < 6; n++) begin
			payload.push_back(8'hFF);
		end
		run_data0(payload);
		check_value("stuffed bits seen", rx_stuffed > 0, 1'b1);
		report_test("all_ones", err_start);
	endtask

	task automatic test_empty_fifo();
		byte_q_t payload;
		int err_start;
		err_start = errors;
		run_data0(payload); // CRC of nothing is all zeros
		report_test("empty_fifo", err_start);
	endtask

	task automatic test_bad_code();
		int pulses;
		int err_start;
		err_start = errors;
		pulses = 0;
		tx_packet = 3'b111;
		@(negedge clk);
		tx_packet = usb_tx_pkg::REQ_NONE;
		for (int n = 0; n < 50; n++) begin
			if (tx_err === 1'b1) begin
				pulses++;
			end
			check_value("tx_transfer_active on bad code", tx_transfer_active, 1'b0);
			check_value("line on bad code", {dp, dm}, 2'b10);
			@(negedge clk);
		end
		check_value("tx_err pulses", pulses, 1);
		report_test("bad_code", err_start);
	endtask

	initial begin
		void'($urandom(32'h3966_851a));
		errors = 0;
		checks = 0;
		n_rst = 1'b0;
		wr_data = 8'h00;
		wr_en = 1'b0;
		tx_packet = usb_tx_pkg::REQ_NONE;
		repeat (10) @(negedge clk);
		n_rst = 1'b1;
		@(negedge clk);
		check_value("line after reset", {dp, dm}, 2'b10);
		check_value("tx_transfer_active after reset", tx_transfer_active, 1'b0);
		test_handshakes();
		test_random_payload();
		test_all_ones();
		test_empty_fifo();
		test_bad_code();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

bind usb_tx tb_usb_tx_assert u_assert (
	.clk(clk),
	.n_rst(n_rst),
	.tx_packet(tx_packet),
	.tx_transfer_active(tx_transfer_active),
	.tx_err(tx_err),
	.dp(dp),
	.dm(dm)
);

`default_nettype wire

/* usb_tx.f */
usb_tx_pkg.sv
usb_tx_fifo.sv
usb_tx_crc16.sv
usb_tx_serializer.sv
usb_tx_encoder.sv
usb_tx_ctrl.sv
usb_tx.sv
tb_usb_tx_assert.sv
tb_usb_tx.sv

/* Bender.yml */
package:
  name: usb_tx

sources:
  - usb_tx_pkg.sv
  - usb_tx_fifo.sv
  - usb_tx_crc16.sv
  - usb_tx_serializer.sv
  - usb_tx_encoder.sv
  - usb_tx_ctrl.sv
  - usb_tx.sv
  - target: test
    files:
      - tb_usb_tx_assert.sv
      - tb_usb_tx.sv
